// ==== Makefile ====
# verilator build and run of the scope testbench
TOP := scope_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

# pass only if the simulation prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module scope_top -f vlog.f

clean:
	rm -rf obj_dir

// ==== test/scope_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_tb;
  import scope_pkg::*;

  // run length in cycles, for the watchdog
  localparam int n_bus  = 40;   // bus accesses, about 4 cycles each
  localparam int n_smp  = 860;  // stream samples over all tests
  localparam int n_trg  = 7;    // trigger events, about 40 cycles each
  localparam int wd_cyc = 8 + n_bus * 4 + n_smp * 3 + n_trg * 40;

  localparam logic [19:0] cfg_regs [7] = '{reg_avg, reg_dec, reg_shr, reg_lvl,
                                           reg_hst, reg_sel, reg_dly};

  logic        clk = 1'b0;
  logic        rstn;
  smp_t        sti_dat;
  logic        sti_vld;
  logic        sti_rdy;
  out_t        sto_dat;
  logic        sto_vld;
  logic        sto_rdy;
  ext_t        trg_ext;
  logic [1:0]  trg_edg;
  logic        trg_out;
  logic [31:0] sys_addr;
  logic [31:0] sys_wdata;
  logic [3:0]  sys_sel;
  logic        sys_wen;
  logic        sys_ren;
  logic [31:0] sys_rdata;
  logic        sys_ack;

  logic [31:0] seed = 32'h3906_d233;
  int          errors = 0;
  int          cyc = 0;      // cycle count, updated with nba
  out_t        exp_q[$];     // expected decimator outputs
  longint      m_acc = 0;    // model window sum
  int          m_cnt = 0;
  logic        m_arm_p = 1'b0;
  logic        m_arm_n = 1'b0;
  logic [1:0]  m_edg = 2'b00;  // edge pulses due next cycle
  int          exp_p = 0;
  int          exp_n = 0;
  int          act_p = 0;
  int          act_n = 0;
  int          n_out = 0;
  int          trg_cnt = 0;
  int          trg_cyc = 0;  // cycle of the last trg_out
  int          acc_cyc = 0;  // cycle of the last bus write
  // shadow of the dut configuration
  logic        m_avg = 1'b0;
  dec_t        m_dec = '0;
  shr_t        m_shr = '0;
  smp_t        m_lvl = '0;
  smp_t        m_hst = '0;

  always #4 clk = ~clk;

  scope_top dut (.*);

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // result of a finished window
  function automatic out_t window_out(input logic avg, input shr_t shr,
                                      input longint sum, input smp_t last);
    longint sh;
    sh = sum >>> shr;  // arithmetic shift, then keep the low bits
    return avg ? out_t'(sh[dwo-1:0]) : out_t'(last);
  endfunction

  function automatic logic [31:0] reg_expect(input logic [19:0] a, input logic [31:0] d);
    case (a)
      reg_avg:          return {31'd0, d[0]};
      reg_dec:          return {15'd0, d[16:0]};
      reg_shr:          return {28'd0, d[3:0]};
      reg_lvl, reg_hst: return {{18{d[13]}}, d[13:0]};  // sign extended
      reg_sel:          return {29'd0, d[2:0]};
      reg_dly:          return {16'd0, d[15:0]};
      default:          return 32'd0;
    endcase
  endfunction

  // schmitt model, returns {arm_n, arm_p, fire_n, fire_p}
  function automatic logic [3:0] edge_step(input smp_t x, input smp_t lvl, input smp_t hst,
                                           input logic arm_p, input logic arm_n);
    int   lo;
    int   hi;
    logic fp;
    logic fn;
    lo = int'(lvl) - int'(hst);
    hi = int'(lvl) + int'(hst);
    fp = arm_p && (int'(x) >= int'(lvl));
    fn = arm_n && (int'(x) <= int'(lvl));
    if (fp) begin
      arm_p = 1'b0;
    end else if (int'(x) < lo) begin
      arm_p = 1'b1;
    end
    if (fn) begin
      arm_n = 1'b0;
    end else if (int'(x) > hi) begin
      arm_n = 1'b1;
    end
    return {arm_n, arm_p, fn, fp};
  endfunction

  // comparator, then the model step for the sample taken at this edge
  always @(posedge clk) begin
    logic [3:0] e;
    out_t       exp_v;
    cyc <= cyc + 1;
    if (rstn) begin
      // input slot free when the output register is empty or draining
      assert (sti_rdy == (!sto_vld || sto_rdy)) else begin
        errors++;
        $display("error sti_rdy exp %h got %h", !sto_vld || sto_rdy, sti_rdy);
      end
      if (sto_vld && sto_rdy) begin
        n_out++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("output sample %h with nothing expected, cycle %0d", sto_dat, cyc);
        end
        if (exp_q.size() != 0) begin
          exp_v = exp_q.pop_front();
          assert (sto_dat == exp_v) else begin
            errors++;
            $display("error sto_dat exp %h got %h", exp_v, sto_dat);
          end
        end
      end
      assert (trg_edg == m_edg) else begin
        errors++;
        $display("error trg_edg exp %h got %h", m_edg, trg_edg);
      end
      act_p += trg_edg[0];
      act_n += trg_edg[1];
      if (trg_out) begin
        trg_cnt++;
        trg_cyc = cyc;
      end
      m_edg = 2'b00;
      if (sti_vld && sti_rdy) begin
        m_acc += longint'(sti_dat);
        m_cnt++;
        if (m_cnt >= ((m_dec == '0) ? 1 : int'(m_dec))) begin  // window done
          exp_q.push_back(window_out(m_avg, m_shr, m_acc, sti_dat));
          m_acc = 0;
          m_cnt = 0;
        end
        e = edge_step(sti_dat, m_lvl, m_hst, m_arm_p, m_arm_n);
        m_arm_n = e[3];
        m_arm_p = e[2];
        m_edg   = e[1:0];
        exp_p  += e[0];
        exp_n  += e[1];
      end
    end
  end

  ////////////////////
  // bus and stream
  ////////////////////

  task automatic bus_access(input logic wr, input logic [19:0] a, input logic [31:0] d,
                            output logic [31:0] rd);
    int   t;
    logic early;
    @(posedge clk);
    sys_addr  <= {12'd0, a};
    sys_wdata <= d;
    sys_wen   <= wr;
    sys_ren   <= !wr;
    @(posedge clk);  // access sampled here
    early = sys_ack;  // ack still low in the access cycle
    sys_wen <= 1'b0;
    sys_ren <= 1'b0;
    acc_cyc = cyc;
    t = 0;
    @(posedge clk);
    while (!sys_ack && t < 16) begin
      t++;
      @(posedge clk);
    end
    assert (!early && sys_ack && t == 0) else begin
      errors++;
      $display("sys_ack for address %h came early, %0d cycles late or never", a, t);
    end
    rd = sys_rdata;
  endtask

  task automatic bus_write(input logic [19:0] a, input logic [31:0] d);
    logic [31:0] rd;
    bus_access(1'b1, a, d, rd);
    case (a)
      reg_avg: m_avg = d[0];
      reg_dec: m_dec = d[dwc-1:0];
      reg_shr: m_shr = d[dws-1:0];
      reg_lvl: m_lvl = d[dwi-1:0];
      reg_hst: m_hst = d[dwi-1:0];
      default: ;
    endcase
  endtask

  task automatic check_read(input logic [19:0] a, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, a, 32'd0, rd);
    assert (rd == exp) else begin
      errors++;
      $display("error sys_rdata @%h exp %h got %h", a, exp, rd);
    end
  endtask

  // n samples, random or random walk, optional random back-pressure
  task automatic send_stream(input int n, input bit walk, input bit bp);
    int   sent;
    smp_t x;
    sent = 0;
    x = '0;
    while (sent < n) begin
      @(posedge clk);
      if (sti_vld && sti_rdy) begin
        sent++;
      end
      seed = lcg_next(seed);
      sto_rdy <= bp ? seed[15] : 1'b1;
      if (sent == n) begin
        sti_vld <= 1'b0;
      end else if (!sti_vld || sti_rdy) begin  // previous sample taken
        x = walk ? x + smp_t'($signed(seed[27:22])) : smp_t'(seed[31:18]);
        sti_dat <= x;
        sti_vld <= 1'b1;
      end
    end
  endtask

  task automatic drain_out(input int base, input int n_exp);
    int t;
    t = 0;
    @(posedge clk);
    sto_rdy <= 1'b1;
    while ((exp_q.size() != 0 || sto_vld) && t < 200) begin
      @(negedge clk);
      t++;
    end
    assert (n_out - base == n_exp && exp_q.size() == 0) else begin
      errors++;
      $display("%0d output windows expected, %0d seen", n_exp, n_out - base);
    end
  endtask

  task automatic wait_trig(input int target);
    int t;
    t = 0;
    while (trg_cnt < target && t < 40) begin
      @(negedge clk);
      t++;
    end
  endtask

  task automatic pulse_ext(input ext_t m);
    @(posedge clk);
    trg_ext <= m;
    repeat (4) @(posedge clk);
    trg_ext <= '0;
    repeat (30) @(posedge clk);  // well past sync plus delay
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    logic [31:0] wd;
    int          base;
    rstn      = 1'b0;
    sti_dat   = '0;
    sti_vld   = 1'b0;
    sto_rdy   = 1'b1;
    trg_ext   = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_sel   = 4'hf;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;

    // register readback
    for (int i = 0; i < 7; i++) begin
      seed = lcg_next(seed);
      wd = seed;
      bus_write(cfg_regs[i], wd);
      check_read(cfg_regs[i], reg_expect(cfg_regs[i], wd));
    end
    check_read(reg_ctl, 32'd0);   // write only
    check_read(20'h00040, 32'd0); // hole
    bus_write(reg_sel, 32'(src_none));
    bus_write(reg_dly, 32'd0);

    // plain decimation
    bus_write(reg_avg, 32'd0);
    for (int d = 1; d <= 5; d += 2) begin
      bus_write(reg_dec, d);
      base = n_out;
      send_stream(d * 4, 1'b0, 1'b0);
      drain_out(base, 4);
    end

    // averaging with back-pressure
    bus_write(reg_avg, 32'd1);
    bus_write(reg_dec, 32'd8);
    bus_write(reg_shr, 32'd3);
    base = n_out;
    send_stream(400, 1'b0, 1'b1);
    drain_out(base, 50);

    // edges on a random walk
    bus_write(reg_lvl, 32'd100);
    bus_write(reg_hst, 32'd40);
    base = n_out;
    send_stream(400, 1'b1, 1'b1);
    drain_out(base, 50);
    @(negedge clk);
    assert (act_p == exp_p && act_n == exp_n) else begin
      errors++;
      $display("error trg_edg count pos exp %h got %h neg exp %h got %h",
               exp_p, act_p, exp_n, act_n);
    end

    // software trigger, event plus delay plus pulse register
    bus_write(reg_dly, 32'd10);
    bus_write(reg_sel, 32'(src_sw));
    base = trg_cnt;
    bus_write(reg_ctl, 32'h2);
    wait_trig(base + 1);
    @(negedge clk);
    assert (trg_cnt == base + 1) else begin
      errors++;
      $display("software trigger gave %0d trg_out pulses instead of one", trg_cnt - base);
    end
    if (trg_cnt == base + 1) begin
      assert (trg_cyc - acc_cyc == 12) else begin
        errors++;
        $display("error trg_out delay exp %h got %h", 12, trg_cyc - acc_cyc);
      end
    end

    // external trigger 2, other lines ignored
    bus_write(reg_sel, 32'(src_ext2));
    base = trg_cnt;
    repeat (3) pulse_ext(4'b0100);
    pulse_ext(4'b0001);
    pulse_ext(4'b0010);
    pulse_ext(4'b1000);
    @(negedge clk);
    assert (trg_cnt - base == 3) else begin
      errors++;
      $display("error trg_out count exp %h got %h", 3, trg_cnt - base);
    end

    // clear in mid window
    base = n_out;
    send_stream(5, 1'b0, 1'b0);
    repeat (2) @(posedge clk);
    bus_write(reg_ctl, 32'h1);
    @(posedge clk);
    m_acc   = 0;  // model drops its partial window too
    m_cnt   = 0;
    m_arm_p = 1'b0;
    m_arm_n = 1'b0;
    send_stream(8, 1'b0, 1'b0);
    drain_out(base, 1);

    repeat (4) @(posedge clk);
    $display("errors %0d, outputs %0d, edges %0d/%0d, triggers %0d",
             errors, n_out, act_p, act_n, trg_cnt);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(wd_cyc * 8 + 2000);
    $display("watchdog expired at cycle %0d, tests did not complete", cyc);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/scope_dec_avg.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_dec_avg (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ctl_clr,  // drop window and pending output
  // configuration
  input  logic            cfg_avg,
  input  scope_pkg::dec_t cfg_dec,
  input  scope_pkg::shr_t cfg_shr,
  // stream in
  input  scope_pkg::smp_t sti_dat,
  input  logic            sti_vld,
  output logic            sti_rdy,
  // stream out
  output scope_pkg::out_t sto_dat,
  output logic            sto_vld,
  input  logic            sto_rdy
);
  import scope_pkg::*;

  logic sti_xfr;  // input sample accepted
  dec_t win_cnt;  // samples already in the window
  dec_t win_lim;  // index of last sample
  logic win_end;
  acc_t acc;      // partial window sum
  acc_t acc_sum;  // sum including current sample
  acc_t acc_shr;
  out_t dat_nxt;  // value for the output register

  // output slot free, or emptied this cycle
  assign sti_rdy = ~sto_vld | sto_rdy;
  assign sti_xfr = sti_vld & sti_rdy;

  // dec of 0 behaves like 1
  assign win_lim = (cfg_dec == '0) ? '0 : cfg_dec - 1'b1;
  assign win_end = (win_cnt >= win_lim);  // >= also covers a shrinking cfg_dec

  assign acc_sum = acc + sti_dat;
  assign acc_shr = acc_sum >>> cfg_shr;  // arithmetic
  // truncated, no saturation
  assign dat_nxt = cfg_avg ? acc_shr[dwo-1:0] : sti_dat[dwo-1:0];

  ////////////////////
  // window
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || ctl_clr) begin
      win_cnt <= '0;
      acc     <= '0;
    end else if (sti_xfr) begin
      if (win_end) begin
        win_cnt <= '0;  // next window starts right away
        acc     <= '0;
      end else begin
        win_cnt <= win_cnt + 1'b1;
        acc     <= acc_sum;
      end
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || ctl_clr) begin
      sto_vld <= 1'b0;
    end else if (sti_xfr && win_end) begin
      sto_vld <= 1'b1;  // load wins over a same cycle drain
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_xfr && win_end) begin
      sto_dat <= dat_nxt;
    end
  end

  // held data does not move until taken
  a_sto_hold: assert property (@(posedge clk) disable iff (!rstn || ctl_clr)
    sto_vld && !sto_rdy |=> sto_vld && $stable(sto_dat))
    else $error("sto_dat changed under back-pressure");

endmodule

`default_nettype wire

// ==== verilog/scope_edge.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_edge (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ctl_clr,  // disarm both sides
  // monitored stream
  input  scope_pkg::smp_t sti_dat,
  input  logic            sti_vld,
  input  logic            sti_rdy,
  // configuration
  input  scope_pkg::smp_t cfg_lvl,
  input  scope_pkg::smp_t cfg_hst,
  // edge pulses
  output logic            trg_pdg,
  output logic            trg_ndg
);
  import scope_pkg::*;

  logic                sti_xfr;
  logic signed [dwi:0] thr_lo;  // one bit wider, no wrap
  logic signed [dwi:0] thr_hi;
  logic                arm_p;   // seen a sample under thr_lo
  logic                arm_n;   // seen a sample over thr_hi
  logic                fire_p;
  logic                fire_n;

  assign sti_xfr = sti_vld & sti_rdy;  // only accepted samples count

  assign thr_lo = cfg_lvl - cfg_hst;
  assign thr_hi = cfg_lvl + cfg_hst;

  assign fire_p = sti_xfr & arm_p & (sti_dat >= cfg_lvl);
  assign fire_n = sti_xfr & arm_n & (sti_dat <= cfg_lvl);

  ////////////////////
  // schmitt state
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || ctl_clr) begin
      arm_p   <= 1'b0;
      arm_n   <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= fire_p;  // pulse one cycle after the sample
      trg_ndg <= fire_n;
      if (fire_p) begin
        arm_p <= 1'b0;
      end else if (sti_xfr && (sti_dat < thr_lo)) begin
        arm_p <= 1'b1;
      end
      if (fire_n) begin
        arm_n <= 1'b0;
      end else if (sti_xfr && (sti_dat > thr_hi)) begin
        arm_n <= 1'b1;
      end
    end
  end

  a_one_edge: assert property (@(posedge clk) disable iff (!rstn)
    !(trg_pdg && trg_ndg))
    else $error("trg_pdg and trg_ndg fired together");

endmodule

`default_nettype wire

// ==== verilog/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned dwi = 14;         // input sample
  localparam int unsigned dwo = 14;         // output sample
  localparam int unsigned dwc = 17;         // decimation counter
  localparam int unsigned dws = 4;          // shift amount
  localparam int unsigned twa = 4;          // external triggers
  localparam int unsigned dwa = dwi + dwc;  // sum of up to 2^dwc samples

  typedef logic signed [dwi-1:0] smp_t;  // adc sample
  typedef logic signed [dwo-1:0] out_t;  // decimated sample
  typedef logic        [dwc-1:0] dec_t;  // decimation factor
  typedef logic        [dws-1:0] shr_t;  // right shift
  typedef logic signed [dwa-1:0] acc_t;  // window sum
  typedef logic          [16-1:0] dly_t;  // trigger delay, clock cycles
  typedef logic        [twa-1:0] ext_t;  // external trigger lines

  // trigger source select
  typedef enum logic [2:0] {
    src_sw   = 3'd0,  // software, reg_ctl bit 1
    src_pdg  = 3'd1,  // positive edge on adc
    src_ndg  = 3'd2,  // negative edge on adc
    src_ext0 = 3'd3,
    src_ext1 = 3'd4,
    src_ext2 = 3'd5,
    src_ext3 = 3'd6,
    src_none = 3'd7   // trigger off
  } trg_src_e;

  ////////////////////
  // register map, low 20 address bits
  ////////////////////

  localparam logic [19:0] reg_ctl = 20'h00000;  // wo: bit0 clear, bit1 sw trigger
  localparam logic [19:0] reg_avg = 20'h00008;
  localparam logic [19:0] reg_dec = 20'h0000c;
  localparam logic [19:0] reg_shr = 20'h00010;
  localparam logic [19:0] reg_lvl = 20'h00014;
  localparam logic [19:0] reg_hst = 20'h00018;
  localparam logic [19:0] reg_sel = 20'h0001c;
  localparam logic [19:0] reg_dly = 20'h00020;

endpackage

`default_nettype wire

// ==== verilog/scope_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_regs (
  input  logic                clk,
  input  logic                rstn,
  // system bus
  input  logic [31:0]         sys_addr,
  input  logic [31:0]         sys_wdata,
  input  logic [3:0]          sys_sel,    // byte lanes ignored, full-word writes only
  input  logic                sys_wen,
  input  logic                sys_ren,
  output logic [31:0]         sys_rdata,
  output logic                sys_ack,
  // control pulses
  output logic                ctl_clr,
  output logic                trg_sw,
  // configuration
  output logic                cfg_avg,
  output scope_pkg::dec_t     cfg_dec,
  output scope_pkg::shr_t     cfg_shr,
  output scope_pkg::smp_t     cfg_lvl,
  output scope_pkg::smp_t     cfg_hst,
  output scope_pkg::trg_src_e cfg_sel,
  output scope_pkg::dly_t     cfg_dly
);
  import scope_pkg::*;

  logic [19:0] addr;    // offset within the block
  logic        ctl_wr;  // write to the control register

  assign addr   = sys_addr[19:0];
  assign ctl_wr = sys_wen && (addr == reg_ctl);

  ////////////////////
  // ack and pulses
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack <= 1'b0;
      ctl_clr <= 1'b0;
      trg_sw  <= 1'b0;
    end else begin
      sys_ack <= sys_wen | sys_ren;      // one cycle latency, every access
      ctl_clr <= ctl_wr & sys_wdata[0];  // single cycle, self clearing
      trg_sw  <= ctl_wr & sys_wdata[1];
    end
  end

  // config writes
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_sel <= src_none;  // no trigger source out of reset
      cfg_dly <= '0;
    end else if (sys_wen) begin
      case (addr)
        reg_avg: cfg_avg <= sys_wdata[0];
        reg_dec: cfg_dec <= sys_wdata[dwc-1:0];
        reg_shr: cfg_shr <= sys_wdata[dws-1:0];
        reg_lvl: cfg_lvl <= sys_wdata[dwi-1:0];
        reg_hst: cfg_hst <= sys_wdata[dwi-1:0];
        reg_sel: cfg_sel <= trg_src_e'(sys_wdata[2:0]);
        reg_dly: cfg_dly <= sys_wdata[15:0];
        default: ;  // ctl and holes have no storage
      endcase
    end
  end

  // readback, sampled every cycle, qualified by sys_ack
  always_ff @(posedge clk) begin
    case (addr)
      reg_avg: sys_rdata <= {31'd0, cfg_avg};
      reg_dec: sys_rdata <= {{(32-dwc){1'b0}}, cfg_dec};
      reg_shr: sys_rdata <= {{(32-dws){1'b0}}, cfg_shr};
      reg_lvl: sys_rdata <= {{(32-dwi){cfg_lvl[dwi-1]}}, cfg_lvl};  // sign extended
      reg_hst: sys_rdata <= {{(32-dwi){cfg_hst[dwi-1]}}, cfg_hst};
      reg_sel: sys_rdata <= {29'd0, cfg_sel};
      reg_dly: sys_rdata <= {16'd0, cfg_dly};
      default: sys_rdata <= 32'd0;
    endcase
  end

  // one access per cycle, a read or a write
  a_one_access: assert property (@(posedge clk) disable iff (!rstn)
    !(sys_wen && sys_ren))
    else $error("sys_wen and sys_ren high in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/scope_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_top (
  input  logic            clk,
  input  logic            rstn,
  // adc stream in
  input  scope_pkg::smp_t sti_dat,
  input  logic            sti_vld,
  output logic            sti_rdy,
  // decimated stream out
  output scope_pkg::out_t sto_dat,
  output logic            sto_vld,
  input  logic            sto_rdy,
  // triggers
  input  scope_pkg::ext_t trg_ext,
  output logic [1:0]      trg_edg,  // [0] pos, [1] neg
  output logic            trg_out,
  // system bus
  input  logic [31:0]     sys_addr,
  input  logic [31:0]     sys_wdata,
  input  logic [3:0]      sys_sel,
  input  logic            sys_wen,
  input  logic            sys_ren,
  output logic [31:0]     sys_rdata,
  output logic            sys_ack
);
  import scope_pkg::*;

  logic     ctl_clr;  // clear pulse
  logic     trg_sw;   // software trigger pulse
  logic     cfg_avg;
  dec_t     cfg_dec;
  shr_t     cfg_shr;
  smp_t     cfg_lvl;
  smp_t     cfg_hst;
  trg_src_e cfg_sel;
  dly_t     cfg_dly;

  ////////////////////
  // blocks
  ////////////////////

  scope_regs regs (
    .clk, .rstn,
    .sys_addr, .sys_wdata, .sys_sel, .sys_wen, .sys_ren, .sys_rdata, .sys_ack,
    .ctl_clr, .trg_sw,
    .cfg_avg, .cfg_dec, .cfg_shr, .cfg_lvl, .cfg_hst, .cfg_sel, .cfg_dly
  );

  scope_dec_avg dec_avg (
    .clk, .rstn, .ctl_clr,
    .cfg_avg, .cfg_dec, .cfg_shr,
    .sti_dat, .sti_vld, .sti_rdy,
    .sto_dat, .sto_vld, .sto_rdy
  );

  // watches the same handshake as dec_avg
  scope_edge edge_det (
    .clk, .rstn, .ctl_clr,
    .sti_dat, .sti_vld, .sti_rdy,
    .cfg_lvl, .cfg_hst,
    .trg_pdg (trg_edg[0]),
    .trg_ndg (trg_edg[1])
  );

  scope_trigger trigger (
    .clk, .rstn, .ctl_clr,
    .trg_sw,
    .trg_pdg (trg_edg[0]),
    .trg_ndg (trg_edg[1]),
    .trg_ext,
    .cfg_sel, .cfg_dly,
    .trg_out
  );

endmodule

`default_nettype wire

// ==== verilog/scope_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module scope_trigger (
  input  logic                clk,
  input  logic                rstn,
  input  logic                ctl_clr,  // cancels a running delay
  // sources
  input  logic                trg_sw,
  input  logic                trg_pdg,
  input  logic                trg_ndg,
  input  scope_pkg::ext_t     trg_ext,  // asynchronous
  // configuration
  input  scope_pkg::trg_src_e cfg_sel,
  input  scope_pkg::dly_t     cfg_dly,
  output logic                trg_out
);
  import scope_pkg::*;

  typedef enum logic {st_idle, st_count} state_e;

  ext_t   ext_meta;  // first sync stage
  ext_t   ext_sync;
  ext_t   ext_last;  // previous synced value
  ext_t   ext_edg;   // rising edge pulses
  logic   src_evt;   // selected source fired
  state_e state;
  dly_t   dly_cnt;

  ////////////////////
  // external inputs
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ext_meta <= '0;
      ext_sync <= '0;
      ext_last <= '0;
      ext_edg  <= '0;
    end else begin
      ext_meta <= trg_ext;
      ext_sync <= ext_meta;
      ext_last <= ext_sync;
      ext_edg  <= ext_sync & ~ext_last;  // event 3 cycles after the pin
    end
  end

  always_comb begin
    case (cfg_sel)
      src_sw:   src_evt = trg_sw;
      src_pdg:  src_evt = trg_pdg;
      src_ndg:  src_evt = trg_ndg;
      src_ext0: src_evt = ext_edg[0];
      src_ext1: src_evt = ext_edg[1];
      src_ext2: src_evt = ext_edg[2];
      src_ext3: src_evt = ext_edg[3];
      default:  src_evt = 1'b0;  // src_none
    endcase
  end

  // delay fsm, pulse at event + dly + 1
  always_ff @(posedge clk) begin
    if (!rstn || ctl_clr) begin
      state   <= st_idle;
      dly_cnt <= '0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      case (state)
        st_idle: begin
          if (src_evt) begin
            if (cfg_dly == '0) begin
              trg_out <= 1'b1;  // no delay, fire next cycle
            end else begin
              state   <= st_count;
              dly_cnt <= cfg_dly;
            end
          end
        end
        st_count: begin  // events ignored here
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == dly_t'(1)) begin
            trg_out <= 1'b1;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_trg_pulse: assert property (@(posedge clk) disable iff (!rstn)
    trg_out |=> !trg_out)
    else $error("trg_out held longer than one cycle");

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/scope_pkg.sv
verilog/scope_regs.sv
verilog/scope_dec_avg.sv
verilog/scope_edge.sv
verilog/scope_trigger.sv
verilog/scope_top.sv
test/scope_tb.sv
